//--- rtl/lc3b_types.sv
package lc3b_types;

typedef logic [15:0] lc3b_word;

// LC-3b opcodes in ISA order.
typedef enum logic [3:0] {
	op_br   = 4'h0,
	op_add  = 4'h1,
	op_ldb  = 4'h2,
	op_stb  = 4'h3,
	op_jsr  = 4'h4,
	op_and  = 4'h5,
	op_ldr  = 4'h6,
	op_str  = 4'h7,
	op_rti  = 4'h8,
	op_not  = 4'h9,
	op_ldi  = 4'hA,
	op_sti  = 4'hB,
	op_jmp  = 4'hC,
	op_shf  = 4'hD,
	op_lea  = 4'hE,
	op_trap = 4'hF
} lc3b_opcode;

// One-cycle event strobes, one per counter.
typedef struct packed {
	logic i_cache_hit;
	logic i_cache_miss;
	logic d_cache_hit;
	logic d_cache_miss;
	logic l2_cache_hit;
	logic l2_cache_miss;
	logic branch;
	logic mispredict;
	logic stall;
} perf_events_t;

// Same layout as the events. A set bit zeroes that counter.
typedef struct packed {
	logic i_cache_hit;
	logic i_cache_miss;
	logic d_cache_hit;
	logic d_cache_miss;
	logic l2_cache_hit;
	logic l2_cache_miss;
	logic branch;
	logic mispredict;
	logic stall;
} perf_clear_t;

typedef struct packed {
	lc3b_word i_cache_hits;
	lc3b_word i_cache_misses;
	lc3b_word d_cache_hits;
	lc3b_word d_cache_misses;
	lc3b_word l2_cache_hits;
	lc3b_word l2_cache_misses;
	lc3b_word total_branches;
	lc3b_word mispredictions;
	lc3b_word total_stalls;
} perf_counts_t;

localparam int NUM_COUNTERS = 9;

// Counter window at the top of the address space.
localparam lc3b_word ADDR_I_CACHE_HITS   = 16'hFFFF;
localparam lc3b_word ADDR_I_CACHE_MISSES = 16'hFFFE;
localparam lc3b_word ADDR_D_CACHE_HITS   = 16'hFFFD;
localparam lc3b_word ADDR_D_CACHE_MISSES = 16'hFFFC;
localparam lc3b_word ADDR_L2_CACHE_HITS  = 16'hFFFB;
localparam lc3b_word ADDR_L2_CACHE_MISSES = 16'hFFFA;
localparam lc3b_word ADDR_TOTAL_BRANCHES = 16'hFFF9;
localparam lc3b_word ADDR_MISPREDICTIONS = 16'hFFF8;
localparam lc3b_word ADDR_TOTAL_STALLS   = 16'hFFF7;

endpackage : lc3b_types

//--- rtl/perf_event_capture.sv
`timescale 1ns/100ps

module perf_event_capture
(
	input logic clk,
	input logic reset,
	input logic i_cache_access,
	input logic i_cache_hit,
	input logic d_cache_access,
	input logic d_cache_hit,
	input logic l2_access,
	input logic l2_hit,
	input logic branch_resolved,
	input logic mispredict,
	input logic stall,

	output lc3b_types::perf_events_t events
);

import lc3b_types::*;

perf_events_t decoded;

always_comb begin
	// Hit level only counts alongside its access strobe.
	decoded.i_cache_hit = i_cache_access & i_cache_hit;
	decoded.i_cache_miss = i_cache_access & ~i_cache_hit;

	decoded.d_cache_hit = d_cache_access & d_cache_hit;
	decoded.d_cache_miss = d_cache_access & ~d_cache_hit;

	decoded.l2_cache_hit = l2_access & l2_hit;
	decoded.l2_cache_miss = l2_access & ~l2_hit;

	decoded.branch = branch_resolved;
	decoded.mispredict = branch_resolved & mispredict; // Valid with the strobe.

	decoded.stall = stall; // Every stalled cycle.
end

// One cycle of latency into the bank.
always_ff @(posedge clk) begin
	if (reset)
		events <= '0;
	else
		events <= decoded;
end

endmodule : perf_event_capture

//--- rtl/perf_counter_bank.sv
`timescale 1ns/100ps

module perf_counter_bank
(
	input logic clk,
	input logic reset,
	input lc3b_types::perf_events_t events,
	input lc3b_types::perf_clear_t clears,

	output lc3b_types::perf_counts_t counts
);

import lc3b_types::*;

logic [NUM_COUNTERS-1:0] event_bits;
logic [NUM_COUNTERS-1:0] clear_bits;
lc3b_word count_regs [NUM_COUNTERS];

// Index 0 is i-cache hits, index 8 is stalls.
assign event_bits = {
	events.stall,
	events.mispredict,
	events.branch,
	events.l2_cache_miss,
	events.l2_cache_hit,
	events.d_cache_miss,
	events.d_cache_hit,
	events.i_cache_miss,
	events.i_cache_hit
};

assign clear_bits = {
	clears.stall,
	clears.mispredict,
	clears.branch,
	clears.l2_cache_miss,
	clears.l2_cache_hit,
	clears.d_cache_miss,
	clears.d_cache_hit,
	clears.i_cache_miss,
	clears.i_cache_hit
};

// Clear beats a coincident event.
always_ff @(posedge clk) begin
	for (int i = 0; i < NUM_COUNTERS; i++) begin
		if (reset || clear_bits[i])
			count_regs[i] <= '0;
		else if (event_bits[i])
			count_regs[i] <= count_regs[i] + 16'd1; // Wraps at FFFF.
	end
end

always_comb begin
	counts.i_cache_hits = count_regs[0];
	counts.i_cache_misses = count_regs[1];
	counts.d_cache_hits = count_regs[2];
	counts.d_cache_misses = count_regs[3];
	counts.l2_cache_hits = count_regs[4];
	counts.l2_cache_misses = count_regs[5];
	counts.total_branches = count_regs[6];
	counts.mispredictions = count_regs[7];
	counts.total_stalls = count_regs[8];
end

endmodule : perf_counter_bank

//--- rtl/mmio_counters.sv
`timescale 1ns/100ps

module mmio_counters
(
	input lc3b_types::lc3b_opcode opcode,
	input lc3b_types::lc3b_word mem_address,
	input lc3b_types::lc3b_word mem_rdata,
	input lc3b_types::perf_counts_t counts,

	output lc3b_types::perf_clear_t clears,
	output lc3b_types::lc3b_word cpu_rdata
);

import lc3b_types::*;

logic is_ldi;
logic is_sti;

assign is_ldi = (opcode == op_ldi);
assign is_sti = (opcode == op_sti);

// Store to a counter address clears it.
always_comb begin
	clears = '0;

	if (is_sti) begin
		case (mem_address)
			ADDR_I_CACHE_HITS:
				clears.i_cache_hit = 1'b1;

			ADDR_I_CACHE_MISSES:
				clears.i_cache_miss = 1'b1;

			ADDR_D_CACHE_HITS:
				clears.d_cache_hit = 1'b1;

			ADDR_D_CACHE_MISSES:
				clears.d_cache_miss = 1'b1;

			ADDR_L2_CACHE_HITS:
				clears.l2_cache_hit = 1'b1;

			ADDR_L2_CACHE_MISSES:
				clears.l2_cache_miss = 1'b1;

			ADDR_TOTAL_BRANCHES:
				clears.branch = 1'b1;

			ADDR_MISPREDICTIONS:
				clears.mispredict = 1'b1;

			ADDR_TOTAL_STALLS:
				clears.stall = 1'b1;

			default: begin
				clears = '0; // Outside the window.
			end
		endcase
	end
end

// Load from a counter address returns the count.
always_comb begin
	cpu_rdata = mem_rdata;

	if (is_ldi) begin
		case (mem_address)
			ADDR_I_CACHE_HITS:
				cpu_rdata = counts.i_cache_hits;

			ADDR_I_CACHE_MISSES:
				cpu_rdata = counts.i_cache_misses;

			ADDR_D_CACHE_HITS:
				cpu_rdata = counts.d_cache_hits;

			ADDR_D_CACHE_MISSES:
				cpu_rdata = counts.d_cache_misses;

			ADDR_L2_CACHE_HITS:
				cpu_rdata = counts.l2_cache_hits;

			ADDR_L2_CACHE_MISSES:
				cpu_rdata = counts.l2_cache_misses;

			ADDR_TOTAL_BRANCHES:
				cpu_rdata = counts.total_branches;

			ADDR_MISPREDICTIONS:
				cpu_rdata = counts.mispredictions;

			ADDR_TOTAL_STALLS:
				cpu_rdata = counts.total_stalls;

			default: begin
				cpu_rdata = mem_rdata; // Normal memory data.
			end
		endcase
	end
end

endmodule : mmio_counters

//--- rtl/perf_monitor_top.sv
`timescale 1ns/100ps

module perf_monitor_top
(
	input logic clk,
	input logic reset,

	input logic i_cache_access,
	input logic i_cache_hit,
	input logic d_cache_access,
	input logic d_cache_hit,
	input logic l2_access,
	input logic l2_hit,
	input logic branch_resolved,
	input logic mispredict,
	input logic stall,

	input lc3b_types::lc3b_opcode opcode,
	input lc3b_types::lc3b_word mem_address,
	input lc3b_types::lc3b_word mem_rdata,

	output lc3b_types::lc3b_word cpu_rdata
);

import lc3b_types::*;

perf_events_t events;
perf_clear_t clears;
perf_counts_t counts;

perf_event_capture perf_event_capture_inst (
	.clk(clk),
	.reset(reset),
	.i_cache_access(i_cache_access),
	.i_cache_hit(i_cache_hit),
	.d_cache_access(d_cache_access),
	.d_cache_hit(d_cache_hit),
	.l2_access(l2_access),
	.l2_hit(l2_hit),
	.branch_resolved(branch_resolved),
	.mispredict(mispredict),
	.stall(stall),
	.events(events)
);

perf_counter_bank perf_counter_bank_inst (
	.clk(clk),
	.reset(reset),
	.events(events),
	.clears(clears),
	.counts(counts)
);

mmio_counters mmio_counters_inst (
	.opcode(opcode),
	.mem_address(mem_address),
	.mem_rdata(mem_rdata),
	.counts(counts),
	.clears(clears),
	.cpu_rdata(cpu_rdata)
);

endmodule : perf_monitor_top

//--- tb/perf_monitor_tb.sv
`timescale 1ns/100ps

module perf_monitor_tb;

import lc3b_types::*;

localparam int CLK_PERIOD = 8;
localparam int RESET_CYCLES = 4;
localparam int PHASE_CYCLES = 50;
localparam int RANDOM_CYCLES = 3000;
// Reset, four directed phases and the random run, plus a quarter of headroom.
localparam int MAX_CYCLES = (RESET_CYCLES + 4 * PHASE_CYCLES + RANDOM_CYCLES) * 5 / 4;

// Raw pipeline signals, in DUT port order.
typedef struct packed {
	logic i_cache_access;
	logic i_cache_hit;
	logic d_cache_access;
	logic d_cache_hit;
	logic l2_access;
	logic l2_hit;
	logic branch_resolved;
	logic mispredict;
	logic stall;
} raw_inputs_t;

typedef struct packed {
	lc3b_opcode opcode;
	lc3b_word address;
	lc3b_word rdata;
} bus_op_t;

logic clk;
logic reset;
raw_inputs_t raw;
lc3b_opcode opcode;
lc3b_word mem_address;
lc3b_word mem_rdata;
lc3b_word cpu_rdata;

lc3b_word model_count [NUM_COUNTERS]; // Index 0 sits at FFFF.
logic [NUM_COUNTERS-1:0] model_pending;
logic [31:0] lfsr_state;
lc3b_word sampled_rdata;
int cycle_count;

perf_monitor_top perf_monitor_top_inst (
	.clk(clk),
	.reset(reset),
	.i_cache_access(raw.i_cache_access),
	.i_cache_hit(raw.i_cache_hit),
	.d_cache_access(raw.d_cache_access),
	.d_cache_hit(raw.d_cache_hit),
	.l2_access(raw.l2_access),
	.l2_hit(raw.l2_hit),
	.branch_resolved(raw.branch_resolved),
	.mispredict(raw.mispredict),
	.stall(raw.stall),
	.opcode(opcode),
	.mem_address(mem_address),
	.mem_rdata(mem_rdata),
	.cpu_rdata(cpu_rdata)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

always @(posedge clk) begin
	cycle_count = cycle_count + 1;
	if (cycle_count >= MAX_CYCLES) begin
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("Test failures found");
		$fatal(1, "Simulation stopped by the cycle limit");
	end
end

// Galois form, taps 32, 22, 2 and 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

function automatic logic [31:0] take_bits(input int n);
	logic [31:0] bits;
	bits = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_step(lfsr_state);
		bits = {bits[30:0], lfsr_state[0]}; // One step per bit.
	end
	return bits;
endfunction

function automatic logic [NUM_COUNTERS-1:0] decode_events(input raw_inputs_t r);
	logic [NUM_COUNTERS-1:0] ev;
	ev[0] = r.i_cache_access && r.i_cache_hit;
	ev[1] = r.i_cache_access && !r.i_cache_hit;
	ev[2] = r.d_cache_access && r.d_cache_hit;
	ev[3] = r.d_cache_access && !r.d_cache_hit;
	ev[4] = r.l2_access && r.l2_hit;
	ev[5] = r.l2_access && !r.l2_hit;
	ev[6] = r.branch_resolved;
	ev[7] = r.branch_resolved && r.mispredict;
	ev[8] = r.stall;
	return ev;
endfunction

// Counter index for an address, or -1 outside the window.
function automatic int window_index(input lc3b_word addr);
	if (addr >= ADDR_TOTAL_STALLS)
		return int'(ADDR_I_CACHE_HITS - addr);
	return -1;
endfunction

function automatic lc3b_word index_address(input int idx);
	return ADDR_I_CACHE_HITS - lc3b_word'(idx);
endfunction

function automatic lc3b_word expected_rdata(input bus_op_t op);
	int idx;
	idx = window_index(op.address);
	if (op.opcode == op_ldi && idx >= 0)
		return model_count[idx];
	return op.rdata;
endfunction

function automatic bus_op_t make_op(input lc3b_opcode opc, input lc3b_word addr,
		input lc3b_word data);
	bus_op_t op;
	op.opcode = opc;
	op.address = addr;
	op.rdata = data;
	return op;
endfunction

function automatic raw_inputs_t random_raw();
	logic [31:0] bits;
	bits = take_bits(9);
	return raw_inputs_t'(bits[8:0]);
endfunction

function automatic bus_op_t random_op();
	bus_op_t op;
	logic [31:0] bits;
	logic [2:0] kind;
	bits = take_bits(3);
	kind = bits[2:0];
	case (kind)
		3'd0, 3'd1, 3'd2: op.opcode = op_ldi;
		3'd3: op.opcode = op_sti;
		default: begin
			bits = take_bits(4);
			op.opcode = lc3b_opcode'(bits[3:0]);
		end
	endcase
	bits = take_bits(2);
	if (bits[1:0] == 2'd0) begin
		bits = take_bits(15);
		op.address = {1'b0, bits[14:0]}; // Well below the window.
	end else begin
		bits = take_bits(4);
		op.address = index_address(int'(bits[3:0]) % NUM_COUNTERS);
	end
	bits = take_bits(16);
	op.rdata = bits[15:0];
	return op;
endfunction

task automatic check_word(input string name, input lc3b_word got, input lc3b_word exp);
	if (got !== exp) begin
		$display("FAIL time=%0t %s got=%h exp=%h", $time, name, got, exp);
		$display("Test failures found");
		$fatal(1, "Mismatch on %s", name);
	end
endtask

task automatic update_model(input raw_inputs_t r, input bus_op_t op);
	int idx;
	idx = window_index(op.address);
	for (int i = 0; i < NUM_COUNTERS; i++) begin
		if (op.opcode == op_sti && idx == i)
			model_count[i] = '0; // Clear wins, the pending event is lost.
		else if (model_pending[i])
			model_count[i] = model_count[i] + 16'd1;
	end
	model_pending = decode_events(r);
endtask

task automatic do_cycle(input raw_inputs_t r, input bus_op_t op);
	@(negedge clk);
	raw = r;
	opcode = op.opcode;
	mem_address = op.address;
	mem_rdata = op.rdata;
	#2;
	sampled_rdata = cpu_rdata;
	check_word($sformatf("cpu_rdata @%h", op.address), cpu_rdata, expected_rdata(op));
	@(posedge clk);
	update_model(r, op);
endtask

task automatic check_reset_values();
	for (int i = 0; i < NUM_COUNTERS; i++) begin
		do_cycle('0, make_op(op_ldi, index_address(i), 16'hA5A5));
		check_word("count after reset", sampled_rdata, 16'h0000);
	end
endtask

task automatic check_clears();
	raw_inputs_t all_hits;
	raw_inputs_t all_misses;
	raw_inputs_t pattern;
	all_hits = '1;
	all_misses = 9'b101010111; // Accesses without hits, plus branch and stall.
	for (int c = 0; c < 12; c++)
		do_cycle((c % 2 == 0) ? all_hits : all_misses, make_op(op_add, 16'h3000, 16'h0));
	for (int i = 0; i < NUM_COUNTERS; i++) begin
		pattern = (i == 1 || i == 3 || i == 5) ? all_misses : all_hits;
		do_cycle(pattern, make_op(op_add, index_address(i), 16'h5555));
		do_cycle('0, make_op(op_sti, index_address(i), 16'h0000));
		do_cycle('0, make_op(op_ldi, index_address(i), 16'hFFFF));
		check_word("count after sti", sampled_rdata, 16'h0000);
		do_cycle('0, make_op(op_ldi, index_address((i + 1) % NUM_COUNTERS), 16'h1234));
	end
endtask

task automatic check_pass_through();
	logic [31:0] bits;
	bus_op_t op;
	for (int c = 0; c < 42; c++) begin
		bits = take_bits(16);
		case (c % 6)
			0: op = make_op(op_ldi, {1'b0, bits[14:0]}, bits[15:0]);
			1: op = make_op(op_sti, {1'b0, bits[14:0]}, bits[15:0]);
			2: op = make_op(op_ldi, 16'hFFF6, bits[15:0]); // Just below the window.
			3: op = make_op(op_sti, 16'hFFF6, bits[15:0]);
			4: op = make_op(op_ldr, index_address(c % NUM_COUNTERS), bits[15:0]);
			default: op = make_op(op_str, index_address(c % NUM_COUNTERS), bits[15:0]);
		endcase
		do_cycle(random_raw(), op);
		check_word("pass-through data", sampled_rdata, op.rdata);
	end
	for (int i = 0; i < NUM_COUNTERS; i++)
		do_cycle('0, make_op(op_ldi, index_address(i), 16'h0F0F));
endtask

task automatic check_stall_climb();
	raw_inputs_t stall_only;
	lc3b_word base;
	lc3b_word exp;
	stall_only = '0;
	stall_only.stall = 1'b1;
	base = model_count[8];
	for (int c = 0; c < 48; c++) begin
		do_cycle(stall_only, make_op(op_ldi, ADDR_TOTAL_STALLS, 16'h0000));
		// First stalled cycle shows up two reads later.
		exp = base + lc3b_word'((c >= 2) ? c - 1 : 0);
		check_word("total_stalls step", sampled_rdata, exp);
	end
endtask

initial begin
	cycle_count = 0;
	lfsr_state = 32'h4adc05c9;
	reset = 1'b1;
	raw = '0;
	opcode = op_br;
	mem_address = '0;
	mem_rdata = '0;
	sampled_rdata = '0;
	model_pending = '0;
	for (int i = 0; i < NUM_COUNTERS; i++)
		model_count[i] = '0;

	repeat (RESET_CYCLES) @(posedge clk);
	@(negedge clk);
	reset = 1'b0;

	check_reset_values();
	check_clears();
	check_pass_through();
	check_stall_climb();

	for (int c = 0; c < RANDOM_CYCLES; c++)
		do_cycle(random_raw(), random_op());

	@(negedge clk);
	$display("All tests passed!");
	$finish;
end

endmodule : perf_monitor_tb

//--- all.f
rtl/lc3b_types.sv
rtl/perf_event_capture.sv
rtl/perf_counter_bank.sv
rtl/mmio_counters.sv
rtl/perf_monitor_top.sv
tb/perf_monitor_tb.sv

//--- Makefile
# Verilator build and run for the performance monitor testbench.

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/100ps \
		--top-module perf_monitor_tb -f all.f \
		-o perf_monitor_sim

# Pass only when the simulation prints the pass message.
run: compile
	@out="$$(./obj_dir/perf_monitor_sim 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
